// ==== Bender.yml ====
package:
  name: ram_traffic_driver

sources:
  - files:
      - design/traffic_pkg.sv
      - design/seq_ctrl_if.sv
      - design/byte_lfsr.sv
      - design/addr_counter.sv
      - design/lfsr_data_gen.sv
      - design/read_checker.sv
      - design/test_sequencer.sv
      - design/ram_traffic_driver.sv
  - target: simulation
    files:
      - dv/tb_ram_traffic_driver.sv

// ==== all.f ====
design/traffic_pkg.sv
design/seq_ctrl_if.sv
design/byte_lfsr.sv
design/addr_counter.sv
design/lfsr_data_gen.sv
design/read_checker.sv
design/test_sequencer.sv
design/ram_traffic_driver.sv
dv/tb_ram_traffic_driver.sv

// ==== design/addr_counter.sv ====
// -------------------------------------------------
// sequential column/row/bank address counter
// -------------------------------------------------
`timescale 1ns/1ps

module addr_counter (
  input  logic               clk,
  input  logic               reset_n,
  seq_ctrl_if.addr           ctrl,
  output traffic_pkg::bank_t bank_addr,
  output traffic_pkg::row_t  row_addr,
  output traffic_pkg::col_t  col_addr
);
  import traffic_pkg::*;

  burst_len_t beat;
  logic       step;

  // writes accept every beat, only the first one of a burst moves the address
  assign step = ctrl.cmd_accept && (!ctrl.write_phase || (beat == '0));

  assign ctrl.addr_last = (col_addr == MAX_COL) && (row_addr == MAX_ROW) &&
                          (bank_addr == MAX_BANK);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      beat      <= '0;
      col_addr  <= '0;
      row_addr  <= '0;
      bank_addr <= '0;
    end
    else if (ctrl.addr_clear)
    begin
      beat      <= '0;
      col_addr  <= '0;
      row_addr  <= '0;
      bank_addr <= '0;
    end
    else
    begin
      if (ctrl.cmd_accept && ctrl.write_phase)
      begin
        beat <= (beat == BURST_LEN - burst_len_t'(1)) ? '0 : beat + burst_len_t'(1);
      end
      if (step)
      begin
        if (col_addr == MAX_COL)
        begin
          col_addr <= '0;
          if (row_addr == MAX_ROW)
          begin
            row_addr  <= '0;
            bank_addr <= (bank_addr == MAX_BANK) ? '0 : bank_addr + bank_t'(1);
          end
          else
          begin
            row_addr <= row_addr + row_t'(1);
          end
        end
        else
        begin
          col_addr <= col_addr + COL_STEP;
        end
      end
    end
  end

  a_col_in_range: assert property (
    @(posedge clk) disable iff (!reset_n)
    col_addr <= MAX_COL
  ) else $error("column address past end of test range");

endmodule

// ==== design/byte_lfsr.sv ====
// -------------------------------------------------
// 8-bit Fibonacci LFSR, x^8+x^6+x^5+x^4+1
// -------------------------------------------------
`timescale 1ns/1ps

module byte_lfsr #(
  parameter traffic_pkg::lane_t SEED = 8'd1
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               load,
  input  logic               advance,
  input  traffic_pkg::lane_t load_value,
  output traffic_pkg::lane_t value
);
  import traffic_pkg::*;

  logic  feedback;
  lane_t shifted;

  // taps 7, 5, 4, 3 shifted in at the bottom
  assign feedback = value[7] ^ value[5] ^ value[4] ^ value[3];
  assign shifted  = {value[LANE_W-2:0], feedback};

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      value <= SEED;
    else if (load)
      value <= load_value;
    else if (advance)
      value <= shifted;
  end

  // all-zero state would lock the generator up
  a_never_zero: assert property (
    @(posedge clk) disable iff (!reset_n)
    value != '0
  ) else $error("LFSR reached the all-zero state");

endmodule

// ==== design/lfsr_data_gen.sv ====
// -------------------------------------------------
// four-lane LFSR data generator with replay
// -------------------------------------------------
`timescale 1ns/1ps

module lfsr_data_gen (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               local_rdata_valid,
  seq_ctrl_if.datagen        ctrl,
  output traffic_pkg::data_t data
);
  import traffic_pkg::*;

  data_t saved_data;
  lane_t lane_value [NUM_LANES];
  logic  advance;

  // same sequence feeds write data and expected read data
  assign advance = ctrl.write_beat || local_rdata_valid;

  // start of the write phase, restored at the start of the reads
  always_ff @(posedge clk)
  begin
    if (ctrl.gen_capture)
      saved_data <= data;
  end

  for (genvar lane = 0; lane < NUM_LANES; lane++)
  begin : g_lane
    byte_lfsr #(
      .SEED (LANE_SEEDS[lane])
    ) lfsr_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .load       (ctrl.gen_reload),
      .advance    (advance),
      .load_value (saved_data[lane*LANE_W +: LANE_W]),
      .value      (lane_value[lane])
    );
  end

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      data[i*LANE_W +: LANE_W] = lane_value[i];
  end

endmodule

// ==== design/ram_traffic_driver.sv ====
// -------------------------------------------------
// memory traffic driver top level
// sequencer, address/data generators, read checker
// -------------------------------------------------
`timescale 1ns/1ps

module ram_traffic_driver (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    local_ready,
  input  logic                    local_rdata_valid,
  input  traffic_pkg::data_t      local_rdata,
  output logic                    local_write_req,
  output logic                    local_read_req,
  output logic                    local_burstbegin,
  output traffic_pkg::burst_len_t local_size,
  output traffic_pkg::bank_t      local_bank_addr,
  output traffic_pkg::row_t       local_row_addr,
  output traffic_pkg::col_t       local_col_addr,
  output traffic_pkg::data_t      local_wdata,
  output traffic_pkg::lane_mask_t pnf_per_byte,
  output logic                    pnf_persist,
  output logic                    test_complete
);
  import traffic_pkg::*;

  seq_ctrl_if ctrl_if ();

  // fixed burst size on every command
  assign local_size = BURST_LEN;

  // -------------------------------------------------
  // command sequencing
  // -------------------------------------------------
  test_sequencer test_sequencer_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .write_req         (local_write_req),
    .read_req          (local_read_req),
    .burst_begin       (local_burstbegin),
    .test_complete     (test_complete),
    .ctrl              (ctrl_if.sequencer)
  );

  // -------------------------------------------------
  // address and data generation
  // -------------------------------------------------
  addr_counter addr_counter_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .ctrl      (ctrl_if.addr),
    .bank_addr (local_bank_addr),
    .row_addr  (local_row_addr),
    .col_addr  (local_col_addr)
  );

  // generator output doubles as the expected read word
  lfsr_data_gen lfsr_data_gen_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_rdata_valid (local_rdata_valid),
    .ctrl              (ctrl_if.datagen),
    .data              (local_wdata)
  );

  // -------------------------------------------------
  // read checking
  // -------------------------------------------------
  read_checker read_checker_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_rdata_valid (local_rdata_valid),
    .local_rdata       (local_rdata),
    .expected          (local_wdata),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist)
  );

endmodule

// ==== design/read_checker.sv ====
// -------------------------------------------------
// read checker
// per-lane compare, per-byte and sticky pass flags
// -------------------------------------------------
`timescale 1ns/1ps

module read_checker (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    local_rdata_valid,
  input  traffic_pkg::data_t      local_rdata,
  input  traffic_pkg::data_t      expected,
  output traffic_pkg::lane_mask_t pnf_per_byte,
  output logic                    pnf_persist
);
  import traffic_pkg::*;

  lane_mask_t lane_match;
  lane_mask_t compare_reg;
  lane_mask_t compare_valid;
  logic       valid_d;
  logic       seen;
  logic       seen_d;
  logic       seen_d2;
  logic       persist_int;

  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
      lane_match[i] = local_rdata[i*LANE_W +: LANE_W] == expected[i*LANE_W +: LANE_W];
  end

  // -------------------------------------------------
  // compare pipeline
  // -------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      valid_d       <= 1'b0;
      compare_reg   <= '1;
      compare_valid <= '1;
      pnf_per_byte  <= '1;
      seen          <= 1'b0;
      seen_d        <= 1'b0;
      seen_d2       <= 1'b0;
      persist_int   <= 1'b0;
      pnf_persist   <= 1'b0;
    end
    else
    begin
      valid_d     <= local_rdata_valid;
      compare_reg <= lane_match;
      // hold the last checked beat between valid beats
      if (valid_d)
        compare_valid <= compare_reg;
      pnf_per_byte <= compare_valid;

      if (local_rdata_valid)
        seen <= 1'b1;
      seen_d  <= seen;
      seen_d2 <= seen_d;
      // armed once by the first beat, then it can only fall
      persist_int <= (&compare_valid) && seen_d && (persist_int || !seen_d2);
      pnf_persist <= persist_int;
    end
  end

endmodule

// ==== design/seq_ctrl_if.sv ====
// -------------------------------------------------
// sequencer control to address and data generators
// -------------------------------------------------
`timescale 1ns/1ps

interface seq_ctrl_if;
  logic cmd_accept;
  logic write_phase;
  logic write_beat;
  logic addr_clear;
  logic gen_capture;
  logic gen_reload;
  // high while the current address is the last of the range
  logic addr_last;

  modport sequencer (
    output cmd_accept, write_phase, write_beat, addr_clear, gen_capture, gen_reload,
    input  addr_last
  );

  modport addr (
    input  cmd_accept, write_phase, addr_clear,
    output addr_last
  );

  modport datagen (
    input write_beat, gen_capture, gen_reload
  );
endinterface

// ==== design/test_sequencer.sv ====
// -------------------------------------------------
// test sequencer
// write phase then read phase, outstanding read count
// -------------------------------------------------
`timescale 1ns/1ps

module test_sequencer (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          local_ready,
  input  logic          local_rdata_valid,
  output logic          write_req,
  output logic          read_req,
  output logic          burst_begin,
  output logic          test_complete,
  seq_ctrl_if.sequencer ctrl
);
  import traffic_pkg::*;

  seq_state_t            state;
  burst_len_t            beat_cnt;
  logic                  final_burst;
  logic                  read_accept;
  logic [READ_CNT_W-1:0] rd_outstanding;

  // -------------------------------------------------
  // handshake decode
  // -------------------------------------------------
  assign read_accept      = read_req && local_ready;
  assign ctrl.write_beat  = write_req && local_ready;
  assign ctrl.cmd_accept  = ctrl.write_beat || read_accept;
  assign ctrl.write_phase = (state == write_first) || (state == write_beat);

  // idle saves the generator, the gap cycle before the reads replays it
  assign ctrl.gen_capture = (state == idle);
  assign ctrl.gen_reload  = (state == read_cmd) && !read_req;
  assign ctrl.addr_clear  = ctrl.gen_capture || ctrl.gen_reload;

  // -------------------------------------------------
  // read beats still in flight
  // -------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rd_outstanding <= '0;
    end
    else if (read_accept && local_rdata_valid)
    begin
      rd_outstanding <= rd_outstanding + READ_CNT_W'(BURST_LEN) - READ_CNT_W'(1);
    end
    else if (read_accept)
    begin
      rd_outstanding <= rd_outstanding + READ_CNT_W'(BURST_LEN);
    end
    else if (local_rdata_valid)
    begin
      rd_outstanding <= rd_outstanding - READ_CNT_W'(1);
    end
  end

  // -------------------------------------------------
  // phase FSM
  // -------------------------------------------------
  // starts in done so the first pass enters idle like every later one
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= done;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      burst_begin   <= 1'b0;
      test_complete <= 1'b0;
      beat_cnt      <= '0;
      final_burst   <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          write_req   <= 1'b1;
          burst_begin <= 1'b1;
          beat_cnt    <= '0;
          state       <= write_first;
        end
        write_first:
        begin
          if (ctrl.write_beat)
          begin
            burst_begin <= 1'b0;
            beat_cnt    <= burst_len_t'(1);
            // address moves on after this beat, so remember the last burst
            final_burst <= ctrl.addr_last;
            state       <= write_beat;
          end
        end
        write_beat:
        begin
          if (ctrl.write_beat)
          begin
            if (beat_cnt == BURST_LEN - burst_len_t'(1))
            begin
              beat_cnt <= '0;
              if (final_burst)
              begin
                write_req <= 1'b0;
                state     <= read_cmd;
              end
              else
              begin
                burst_begin <= 1'b1;
                state       <= write_first;
              end
            end
            else
            begin
              beat_cnt <= beat_cnt + burst_len_t'(1);
            end
          end
        end
        read_cmd:
        begin
          if (!read_req)
          begin
            // every read command is a burst of its own
            read_req    <= 1'b1;
            burst_begin <= 1'b1;
          end
          else if (read_accept && ctrl.addr_last)
          begin
            read_req    <= 1'b0;
            burst_begin <= 1'b0;
            state       <= read_drain;
          end
        end
        read_drain:
        begin
          if (rd_outstanding == '0)
          begin
            test_complete <= 1'b1;
            state         <= done;
          end
        end
        done:
        begin
          test_complete <= 1'b0;
          state         <= idle;
        end
        default:
        begin
          state <= done;
        end
      endcase
    end
  end

  // the memory never returns more beats than were asked for
  a_no_read_underflow: assert property (
    @(posedge clk) disable iff (!reset_n)
    local_rdata_valid |-> (rd_outstanding != '0)
  ) else $error("read beat returned with no read outstanding");

endmodule

// ==== design/traffic_pkg.sv ====
// -------------------------------------------------
// memory traffic driver shared definitions
// widths, test range limits, burst length, seeds
// -------------------------------------------------
package traffic_pkg;

  // -------------------------------------------------
  // widths
  // -------------------------------------------------
  localparam int NUM_LANES  = 4;
  localparam int LANE_W     = 8;
  localparam int DATA_W     = NUM_LANES * LANE_W;
  localparam int ROW_W      = 13;
  localparam int COL_W      = 10;
  localparam int BANK_W     = 3;
  localparam int BURST_W    = 3;
  localparam int READ_CNT_W = 8;

  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [LANE_W-1:0]    lane_t;
  typedef logic [NUM_LANES-1:0] lane_mask_t;
  typedef logic [ROW_W-1:0]     row_t;
  typedef logic [COL_W-1:0]     col_t;
  typedef logic [BANK_W-1:0]    bank_t;
  typedef logic [BURST_W-1:0]   burst_len_t;

  // -------------------------------------------------
  // test range
  // -------------------------------------------------
  // beats per local burst
  localparam burst_len_t BURST_LEN = 3'd2;
  // two beats of a half-rate port cover four columns
  localparam col_t  COL_STEP = 10'd4;
  localparam col_t  MAX_COL  = 10'd16;
  localparam row_t  MAX_ROW  = 13'd3;
  localparam bank_t MAX_BANK = 3'd7;

  // lane 0 seed in the low byte
  localparam lane_t [NUM_LANES-1:0] LANE_SEEDS = {8'd31, 8'd21, 8'd11, 8'd1};

  // -------------------------------------------------
  // sequencer states
  // -------------------------------------------------
  typedef enum logic [2:0] {
    idle,
    write_first,
    write_beat,
    read_cmd,
    read_drain,
    done
  } seq_state_t;

endpackage

// ==== dv/ram_traffic_trace.txt ====
// memory traffic driver trace, one hex value per line
// stall percent, corrupted pass, corrupted read beat, corrupted lane, 16 write words
19        // local_ready low in about 25 percent of cycles
2         // pass that gets one corrupted read beat
8B        // read beat 139 of that pass
2         // byte lane 2 is inverted
// first 16 write words, lane 3 in the top byte
1F150B01  // beat 0, the lane seeds
3E2B1702
7D562F04
FBAD5E08
F65BBC11
EDB67823
DB6DF147
B7DAE38E
6FB5C61C
DE6B8D38
BDD61A71
7AAC34E2
F55968C4
EBB2D089
D765A012
AECB4025  // beat 15

// ==== dv/tb_ram_traffic_driver.sv ====
// -------------------------------------------------
// testbench for the memory traffic driver
// trace-driven memory model, scoreboard, watchdog
// -------------------------------------------------
`timescale 1ns/1ps

module tb_ram_traffic_driver;
  import traffic_pkg::*;

  localparam int     NUM_PASSES  = 2;
  localparam int     BURSTS      = 160;
  localparam int     BEATS       = 2 * BURSTS;
  localparam int     NUM_TESTS   = 5;
  localparam longint WATCHDOG_NS = 4 * NUM_PASSES * (BEATS + BEATS + BURSTS * 5) * 10;

  logic       clk;
  logic       reset_n;
  logic       local_ready;
  logic       local_rdata_valid;
  data_t      local_rdata;
  logic       local_write_req;
  logic       local_read_req;
  logic       local_burstbegin;
  burst_len_t local_size;
  bank_t      local_bank_addr;
  row_t       local_row_addr;
  col_t       local_col_addr;
  data_t      local_wdata;
  lane_mask_t pnf_per_byte;
  logic       pnf_persist;
  logic       test_complete;

  // stall percent, corrupted pass/beat/lane, then the first 16 write words
  logic [31:0] trace_mem [0:19];
  data_t       mem [0:7][0:3][0:16][0:1];
  int          stall_pct;
  int          bad_pass;
  int          bad_beat;
  int          bad_lane;
  int          test_errs [NUM_TESTS];
  string       test_names [NUM_TESTS];

  int    cyc;
  int    cur_pass;
  int    passes_done;
  int    wr_words;
  int    wr_beat;
  int    wr_bursts;
  int    rd_bursts;
  int    rd_beats_sent;
  int    rd_beats_back;
  int    last_due;
  int    tc_cyc;
  bank_t wr_bank;
  row_t  wr_row;
  col_t  wr_col;

  // outputs seen at the previous falling edge
  logic  prev_stall;
  logic  prev_wr;
  logic  prev_rd;
  logic  prev_bb;
  logic  prev_tc;
  bank_t prev_bank;
  row_t  prev_row;
  col_t  prev_col;
  data_t prev_wdata;

  int         resp_due [$];
  data_t      resp_data [$];
  lane_mask_t resp_mask [$];
  int         pnf_due [$];
  lane_mask_t pnf_mask [$];
  int         pers_due [$];
  logic       pers_ok [$];
  lane_mask_t exp_pnf;
  logic       seen_beat;
  logic       seen_fail;
  logic       saw_lane_clear;

  ram_traffic_driver ram_traffic_driver_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .local_rdata       (local_rdata),
    .local_write_req   (local_write_req),
    .local_read_req    (local_read_req),
    .local_burstbegin  (local_burstbegin),
    .local_size        (local_size),
    .local_bank_addr   (local_bank_addr),
    .local_row_addr    (local_row_addr),
    .local_col_addr    (local_col_addr),
    .local_wdata       (local_wdata),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_complete     (test_complete)
  );

  always #5 clk = ~clk;

  // -------------------------------------------------
  // helpers
  // -------------------------------------------------
  task automatic compare_value(input int test_id, input string what,
                               input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected)
    begin
      test_errs[test_id]++;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic report_test(input int test_id);
    $display("test %0d %-26s %s (%0d errors)", test_id + 1, test_names[test_id],
             (test_errs[test_id] == 0) ? "passed" : "failed", test_errs[test_id]);
  endtask

  task automatic check_idle_outputs(input string when);
    compare_value(0, {"write_req ", when}, local_write_req, 1'b0);
    compare_value(0, {"read_req ", when}, local_read_req, 1'b0);
    compare_value(0, {"burstbegin ", when}, local_burstbegin, 1'b0);
    compare_value(0, {"test_complete ", when}, test_complete, 1'b0);
    compare_value(0, {"pnf_persist ", when}, pnf_persist, 1'b0);
    compare_value(0, {"pnf_per_byte ", when}, pnf_per_byte, 4'hf);
  endtask

  // column moves fastest, then row, then bank
  function automatic col_t burst_col(input int idx);
    return col_t'((idx % 5) * 4);
  endfunction

  function automatic row_t burst_row(input int idx);
    return row_t'((idx / 5) % 4);
  endfunction

  function automatic bank_t burst_bank(input int idx);
    return bank_t'((idx / 20) % 8);
  endfunction

  task automatic check_burst_addr(input int idx, input string kind);
    compare_value(2, {kind, " bank"}, local_bank_addr, burst_bank(idx));
    compare_value(2, {kind, " row"}, local_row_addr, burst_row(idx));
    compare_value(2, {kind, " column"}, local_col_addr, burst_col(idx));
    compare_value(2, {kind, " burstbegin"}, local_burstbegin, 1'b1);
    compare_value(2, {kind, " size"}, local_size, 3'd2);
  endtask

  // -------------------------------------------------
  // memory model for accepted commands
  // -------------------------------------------------
  task automatic accept_write();
    if (wr_beat == 0)
    begin
      check_burst_addr(wr_bursts, "write");
      wr_bank = local_bank_addr;
      wr_row  = local_row_addr;
      wr_col  = local_col_addr;
    end
    else
    begin
      compare_value(2, "burstbegin on second write beat", local_burstbegin, 1'b0);
    end
    mem[wr_bank][wr_row][wr_col][wr_beat] = local_wdata;
    if (wr_words < 16)
    begin
      compare_value(1, $sformatf("write word %0d", wr_words), local_wdata,
                    trace_mem[4 + wr_words]);
      wr_words++;
    end
    if (wr_beat == 1)
      wr_bursts++;
    wr_beat = 1 - wr_beat;
  endtask

  // two beats back in order 2 to 5 cycles after the command
  task automatic accept_read();
    lane_mask_t mask;
    data_t      word;
    int         due;
    check_burst_addr(rd_bursts, "read");
    due = cyc + 2 + int'($urandom % 4);
    if (due <= last_due)
      due = last_due + 1;
    for (int b = 0; b < 2; b++)
    begin
      mask = '1;
      word = mem[local_bank_addr][local_row_addr][local_col_addr][b];
      if (cur_pass == bad_pass && rd_beats_sent == bad_beat)
      begin
        word[bad_lane*8 +: 8] = ~word[bad_lane*8 +: 8];
        mask[bad_lane]        = 1'b0;
      end
      resp_due.push_back(due + b);
      resp_data.push_back(word);
      resp_mask.push_back(mask);
      rd_beats_sent++;
    end
    last_due = due + 1;
    rd_bursts++;
  endtask

  // -------------------------------------------------
  // local port model on every falling edge
  // -------------------------------------------------
  always @(negedge clk)
  begin : port_model
    logic       rdy;
    int         chk;
    lane_mask_t mask;
    if (reset_n)
    begin
      // one seed for the stall and latency draws
      if (cyc == 0)
        void'($urandom(80));
      cyc++;
      chk = (cur_pass == 1) ? 3 : 4;

      // pnf_per_byte 3 cycles and pnf_persist 4 cycles after a valid beat
      while (pnf_due.size() > 0 && pnf_due[0] <= cyc)
      begin
        void'(pnf_due.pop_front());
        exp_pnf = pnf_mask.pop_front();
      end
      while (pers_due.size() > 0 && pers_due[0] <= cyc)
      begin
        void'(pers_due.pop_front());
        seen_beat = 1'b1;
        if (!pers_ok.pop_front())
          seen_fail = 1'b1;
      end
      compare_value(chk, "pnf_per_byte", pnf_per_byte, exp_pnf);
      compare_value(chk, "pnf_persist", pnf_persist, seen_beat && !seen_fail);
      if (cur_pass == bad_pass && pnf_per_byte[bad_lane] == 1'b0)
        saw_lane_clear = 1'b1;

      if (prev_stall)
      begin
        compare_value(1, "write_req held", local_write_req, prev_wr);
        compare_value(1, "read_req held", local_read_req, prev_rd);
        compare_value(1, "burstbegin held", local_burstbegin, prev_bb);
        compare_value(1, "bank held", local_bank_addr, prev_bank);
        compare_value(1, "row held", local_row_addr, prev_row);
        compare_value(1, "column held", local_col_addr, prev_col);
        if (prev_wr)
          compare_value(1, "write data held", local_wdata, prev_wdata);
      end

      if (local_write_req && !prev_wr && passes_done > 0)
        compare_value(3, "cycles from test_complete to write_req", cyc - tc_cyc, 2);

      if (test_complete)
      begin
        compare_value(3, "test_complete longer than one cycle", prev_tc, 1'b0);
        compare_value(3, "read beats back at test_complete", rd_beats_back, BEATS);
        compare_value(2, "write bursts in pass", wr_bursts, BURSTS);
        compare_value(2, "read bursts in pass", rd_bursts, BURSTS);
        tc_cyc        = cyc;
        passes_done   = passes_done + 1;
        cur_pass      = cur_pass + 1;
        wr_bursts     = 0;
        rd_bursts     = 0;
        rd_beats_sent = 0;
        rd_beats_back = 0;
        wr_beat       = 0;
      end

      rdy = ($urandom % 100) >= stall_pct;
      if (local_write_req && rdy)
        accept_write();
      if (local_read_req && rdy)
        accept_read();

      if (resp_due.size() > 0 && resp_due[0] <= cyc)
      begin
        void'(resp_due.pop_front());
        mask = resp_mask.pop_front();
        local_rdata       <= resp_data.pop_front();
        local_rdata_valid <= 1'b1;
        pnf_due.push_back(cyc + 3);
        pnf_mask.push_back(mask);
        pers_due.push_back(cyc + 4);
        pers_ok.push_back(&mask);
        rd_beats_back++;
      end
      else
      begin
        local_rdata_valid <= 1'b0;
        local_rdata       <= $urandom;
      end
      local_ready <= rdy;

      prev_stall = (local_write_req || local_read_req) && !rdy;
      prev_wr    = local_write_req;
      prev_rd    = local_read_req;
      prev_bb    = local_burstbegin;
      prev_tc    = test_complete;
      prev_bank  = local_bank_addr;
      prev_row   = local_row_addr;
      prev_col   = local_col_addr;
      prev_wdata = local_wdata;
    end
  end

  // -------------------------------------------------
  // main sequence
  // -------------------------------------------------
  initial
  begin : main
    int total_errs;
    int failed_tests;
    clk               = 1'b0;
    reset_n           = 1'b0;
    local_ready       = 1'b0;
    local_rdata_valid = 1'b0;
    local_rdata       = '0;
    cyc = 0;
    cur_pass = 1;
    passes_done = 0;
    wr_words = 0;
    wr_beat = 0;
    wr_bursts = 0;
    rd_bursts = 0;
    rd_beats_sent = 0;
    rd_beats_back = 0;
    last_due = 0;
    tc_cyc = 0;
    prev_stall = 1'b0;
    prev_wr = 1'b0;
    prev_tc = 1'b0;
    exp_pnf = '1;
    seen_beat = 1'b0;
    seen_fail = 1'b0;
    saw_lane_clear = 1'b0;
    test_names = '{"reset state", "write data", "address order and bursts",
                   "clean read-back", "error detection"};
    foreach (test_errs[i])
      test_errs[i] = 0;

    $readmemh("dv/ram_traffic_trace.txt", trace_mem);
    stall_pct = trace_mem[0];
    bad_pass  = trace_mem[1];
    bad_beat  = trace_mem[2];
    bad_lane  = trace_mem[3];

    repeat (2) @(posedge clk);
    @(negedge clk);
    check_idle_outputs("during reset");
    reset_n <= 1'b1;
    @(negedge clk);
    check_idle_outputs("after reset");
    // second rising edge after release starts the writes
    @(negedge clk);
    compare_value(0, "write_req after reset", local_write_req, 1'b1);
    compare_value(0, "burstbegin after reset", local_burstbegin, 1'b1);
    report_test(0);

    wait (passes_done >= NUM_PASSES);
    repeat (8) @(negedge clk);
    compare_value(1, "write words checked against the trace", wr_words, 16);
    compare_value(4, "corrupted lane cleared in pnf_per_byte", saw_lane_clear, 1'b1);
    compare_value(4, "pnf_persist after corruption", pnf_persist, 1'b0);
    report_test(1);
    report_test(2);
    report_test(3);
    report_test(4);

    total_errs   = 0;
    failed_tests = 0;
    foreach (test_errs[i])
    begin
      total_errs += test_errs[i];
      if (test_errs[i] != 0)
        failed_tests++;
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
             NUM_TESTS - failed_tests, failed_tests, total_errs);
    if (total_errs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the test passes did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation FAILED");
    $finish;
  end

endmodule
